// File: Bender.yml
package:
  name: rv_decode

export_include_dirs:
  - design

sources:
  - design/rv_pkg.sv
  - design/rv_decode_if.sv
  - design/rv_decoder.sv
  - design/rv_regfile.sv
  - design/rv_bcu.sv
  - design/rv_agu.sv
  - design/rv_decode_stage.sv
  - design/rv_decode_top.sv
  - target: test
    files:
      - testbench/tb_rv_decode.sv

// File: design/rv_agu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_agu import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] rdata1,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [`RV_XLEN-1:0] pc,
  input  logic                jal,
  input  logic                jalr,
  input  logic                branch,
  input  logic                load,
  input  logic                store,
  input  rv_lsu_op_e          lsu_op,
  output logic [`RV_XLEN-1:0] address,
  output logic [3:0]          byteenable,
  output logic                exception,
  output rv_ecause_e          ecause
);

  logic [`RV_XLEN-1:0] reg_sum;
  logic [`RV_XLEN-1:0] pc_sum;

  assign reg_sum = rdata1 + imm;
  assign pc_sum  = pc + imm;

  always_comb begin
    address    = '0;
    byteenable = 4'b0000;
    exception  = 1'b0;
    ecause     = exc_instr_misaligned;

    if (load || store) begin
      address = reg_sum;
      ecause  = load ? exc_load_misaligned : exc_store_misaligned;
      case (lsu_op)
        lsu_lb, lsu_lbu, lsu_sb: byteenable = 4'b0001 << address[1:0];
        lsu_lh, lsu_lhu, lsu_sh: begin
          byteenable = 4'b0011 << address[1:0];
          exception  = address[0];
        end
        lsu_lw, lsu_sw: begin
          byteenable = 4'b1111;
          exception  = |address[1:0];
        end
        default: byteenable = 4'b0000;
      endcase
    end else if (jalr) begin
      address   = {reg_sum[`RV_XLEN-1:1], 1'b0};
      exception = address[1];
    end else if (jal || branch) begin
      address   = pc_sum;
      exception = address[1]; // Only 32-bit targets
    end
  end

endmodule

`default_nettype wire

// File: design/rv_bcu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_bcu import rv_pkg::*; (
  input  logic [`RV_XLEN-1:0] rdata1,
  input  logic [`RV_XLEN-1:0] rdata2,
  input  rv_bcu_op_e          bcu_op,
  output logic                taken
);

  always_comb begin
    case (bcu_op)
      bcu_beq:  taken = (rdata1 == rdata2);
      bcu_bne:  taken = (rdata1 != rdata2);
      bcu_blt:  taken = ($signed(rdata1) < $signed(rdata2));
      bcu_bge:  taken = ($signed(rdata1) >= $signed(rdata2));
      bcu_bltu: taken = (rdata1 < rdata2);
      bcu_bgeu: taken = (rdata1 >= rdata2);
      default:  taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

interface rv_dec_if import rv_pkg::*; ();
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] imm;
  logic                wren;
  logic                rden1;
  logic                rden2;
  logic                lui;
  logic                auipc;
  logic                jal;
  logic                jalr;
  logic                branch;
  logic                load;
  logic                store;
  logic                fence;
  rv_alu_op_e          alu_op;
  rv_bcu_op_e          bcu_op;
  rv_lsu_op_e          lsu_op;
  logic                ecall;
  logic                ebreak;
  logic                valid;

  modport stage (
    output instr,
    input  imm, wren, rden1, rden2, lui, auipc, jal, jalr, branch, load, store, fence,
    input  alu_op, bcu_op, lsu_op, ecall, ebreak, valid
  );

  modport decoder (
    input  instr,
    output imm, wren, rden1, rden2, lui, auipc, jal, jalr, branch, load, store, fence,
    output alu_op, bcu_op, lsu_op, ecall, ebreak, valid
  );
endinterface

interface rv_rf_if ();
  logic                   rden1;
  logic                   rden2;
  logic [`RV_RADDR_W-1:0] raddr1;
  logic [`RV_RADDR_W-1:0] raddr2;
  logic [`RV_XLEN-1:0]    rdata1; // Forwarded
  logic [`RV_XLEN-1:0]    rdata2;

  modport stage (output rden1, rden2, raddr1, raddr2, input rdata1, rdata2);
  modport regfile (input rden1, rden2, raddr1, raddr2, output rdata1, rdata2);
endinterface

`default_nettype wire

// File: design/rv_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode_stage import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`RV_XLEN-1:0]    pc,
  input  logic [`RV_XLEN-1:0]    instr,
  input  logic                   stall,
  input  logic                   clear,
  rv_dec_if.stage                dec,
  rv_rf_if.stage                 rf,
  output logic [`RV_XLEN-1:0]    bcu_rdata1,
  output logic [`RV_XLEN-1:0]    bcu_rdata2,
  output rv_bcu_op_e             bcu_op,
  input  logic                   bcu_taken,
  output logic [`RV_XLEN-1:0]    agu_rdata1,
  output logic [`RV_XLEN-1:0]    agu_imm,
  output logic [`RV_XLEN-1:0]    agu_pc,
  output logic                   agu_jal,
  output logic                   agu_jalr,
  output logic                   agu_branch,
  output logic                   agu_load,
  output logic                   agu_store,
  output rv_lsu_op_e             agu_lsu_op,
  input  logic [`RV_XLEN-1:0]    agu_address,
  input  logic [3:0]             agu_byteenable,
  input  logic                   agu_exception,
  input  rv_ecause_e             agu_ecause,
  output logic                   d_valid,
  output logic [`RV_XLEN-1:0]    d_pc,
  output logic [`RV_XLEN-1:0]    d_npc,
  output logic [`RV_XLEN-1:0]    d_imm,
  output logic [`RV_RADDR_W-1:0] d_waddr,
  output logic                   d_wren,
  output logic [`RV_XLEN-1:0]    d_rdata1,
  output logic [`RV_XLEN-1:0]    d_rdata2,
  output rv_alu_op_e             d_alu_op,
  output rv_lsu_op_e             d_lsu_op,
  output logic                   d_jump,
  output logic [`RV_XLEN-1:0]    d_address,
  output logic                   d_exception,
  output rv_ecause_e             d_ecause,
  output logic [`RV_XLEN-1:0]    d_etval,
  output logic                   mem_valid,
  output logic [`RV_XLEN-1:0]    mem_addr,
  output logic [`RV_XLEN-1:0]    mem_wdata,
  output logic [3:0]             mem_wstrb
);

  rv_decode_reg_t      r, v;
  logic [`RV_XLEN-1:0] instr_q;
  logic                hold;
  logic [`RV_XLEN-1:0] cur_pc;
  logic [`RV_XLEN-1:0] cur_instr;

  // While held, re-decode the registered instruction
  assign hold      = stall & ~clear;
  assign cur_pc    = hold ? r.pc : pc;
  assign cur_instr = hold ? instr_q : instr;

  assign dec.instr = cur_instr;
  assign rf.rden1  = dec.rden1;
  assign rf.rden2  = dec.rden2;
  assign rf.raddr1 = cur_instr[19:15];
  assign rf.raddr2 = cur_instr[24:20];

  assign bcu_rdata1 = rf.rdata1;
  assign bcu_rdata2 = rf.rdata2;
  assign bcu_op     = dec.bcu_op;

  assign agu_rdata1 = rf.rdata1;
  assign agu_imm    = dec.imm;
  assign agu_pc     = cur_pc;
  assign agu_jal    = dec.jal;
  assign agu_jalr   = dec.jalr;
  assign agu_branch = dec.branch;
  assign agu_load   = dec.load;
  assign agu_store  = dec.store;
  assign agu_lsu_op = dec.lsu_op;

  always_comb begin
    v = rv_decode_reset;
    v.valid  = dec.valid;
    v.pc     = cur_pc;
    v.npc    = cur_pc + `RV_XLEN'd4;
    v.imm    = dec.imm;
    v.waddr  = cur_instr[11:7];
    v.wren   = dec.wren;
    v.rdata1 = rf.rdata1;
    v.rdata2 = rf.rdata2;
    v.alu_op = dec.alu_op;
    v.bcu_op = dec.bcu_op;
    v.lsu_op = dec.lsu_op;
    {v.lui, v.auipc, v.jal, v.jalr} = {dec.lui, dec.auipc, dec.jal, dec.jalr};
    {v.branch, v.load, v.store, v.fence} = {dec.branch, dec.load, dec.store, dec.fence};
    v.jump       = dec.jal | dec.jalr | bcu_taken;
    v.address    = agu_address;
    v.byteenable = agu_byteenable;
    v.exception  = agu_exception;
    v.ecause     = agu_ecause;
    v.etval      = agu_address;

    if (v.exception) begin
      if (v.load) begin
        {v.load, v.wren} = 2'b00;
      end else if (v.store) begin
        v.store = 1'b0;
      end else if (v.jump) begin
        {v.jump, v.wren} = 2'b00;
      end else begin
        v.exception = 1'b0; // Untaken branch or plain ALU op
      end
    end

    if (!dec.valid) begin
      v.exception = 1'b1;
      v.ecause    = exc_illegal_instr;
      v.etval     = cur_instr;
      {v.wren, v.jump, v.load, v.store} = 4'b0000;
    end else if (dec.ebreak) begin
      v.exception = 1'b1;
      v.ecause    = exc_breakpoint;
      v.etval     = cur_instr;
    end else if (dec.ecall) begin
      v.exception = 1'b1;
      v.ecause    = exc_ecall;
      v.etval     = cur_instr;
    end

    if (clear) begin
      {v.valid, v.wren, v.jump, v.load, v.store, v.exception} = 6'b000000;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      r       <= rv_decode_reset;
      instr_q <= '0;
    end else if (!hold) begin
      r       <= v;
      instr_q <= instr;
    end
  end

  // A squashed instruction stays quiet while held
  assign mem_valid = (v.load | v.store) & (r.valid | ~hold);
  assign mem_addr  = v.address;
  assign mem_wstrb = dec.load ? 4'b0000 : v.byteenable;

  always_comb begin
    case (v.lsu_op)
      lsu_sb:  mem_wdata = {4{v.rdata2[7:0]}};
      lsu_sh:  mem_wdata = {2{v.rdata2[15:0]}};
      default: mem_wdata = v.rdata2;
    endcase
  end

  assign d_valid     = r.valid;
  assign d_pc        = r.pc;
  assign d_npc       = r.npc;
  assign d_imm       = r.imm;
  assign d_waddr     = r.waddr;
  assign d_wren      = r.wren;
  assign d_rdata1    = r.rdata1;
  assign d_rdata2    = r.rdata2;
  assign d_alu_op    = r.alu_op;
  assign d_lsu_op    = r.lsu_op;
  assign d_jump      = r.jump;
  assign d_address   = r.address;
  assign d_exception = r.exception;
  assign d_ecause    = r.ecause;
  assign d_etval     = r.etval;

endmodule

`default_nettype wire

// File: design/rv_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decode_top import rv_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`RV_XLEN-1:0]    pc,
  input  logic [`RV_XLEN-1:0]    instr,
  input  logic                   stall,
  input  logic                   clear,
  input  logic                   wb_wren,
  input  logic [`RV_RADDR_W-1:0] wb_waddr,
  input  logic [`RV_XLEN-1:0]    wb_wdata,
  input  logic                   ex_wren,
  input  logic [`RV_RADDR_W-1:0] ex_waddr,
  input  logic [`RV_XLEN-1:0]    ex_wdata,
  output logic                   d_valid,
  output logic [`RV_XLEN-1:0]    d_pc,
  output logic [`RV_XLEN-1:0]    d_npc,
  output logic [`RV_XLEN-1:0]    d_imm,
  output logic [`RV_RADDR_W-1:0] d_waddr,
  output logic                   d_wren,
  output logic [`RV_XLEN-1:0]    d_rdata1,
  output logic [`RV_XLEN-1:0]    d_rdata2,
  output rv_alu_op_e             d_alu_op,
  output rv_lsu_op_e             d_lsu_op,
  output logic                   d_jump,
  output logic [`RV_XLEN-1:0]    d_address,
  output logic                   d_exception,
  output rv_ecause_e             d_ecause,
  output logic [`RV_XLEN-1:0]    d_etval,
  output logic                   mem_valid,
  output logic [`RV_XLEN-1:0]    mem_addr,
  output logic [`RV_XLEN-1:0]    mem_wdata,
  output logic [3:0]             mem_wstrb
);

  logic [`RV_XLEN-1:0] bcu_rdata1, bcu_rdata2;
  rv_bcu_op_e          bcu_op;
  logic                bcu_taken;
  logic [`RV_XLEN-1:0] agu_rdata1, agu_imm, agu_pc, agu_address;
  logic                agu_jal, agu_jalr, agu_branch, agu_load, agu_store;
  rv_lsu_op_e          agu_lsu_op;
  logic [3:0]          agu_byteenable;
  logic                agu_exception;
  rv_ecause_e          agu_ecause;

  rv_dec_if u_dec_if ();
  rv_rf_if  u_rf_if ();

  rv_decode_stage u_rv_decode_stage (
    .clk, .rst, .pc, .instr, .stall, .clear,
    .dec (u_dec_if.stage),
    .rf  (u_rf_if.stage),
    .bcu_rdata1, .bcu_rdata2, .bcu_op, .bcu_taken,
    .agu_rdata1, .agu_imm, .agu_pc, .agu_jal, .agu_jalr, .agu_branch,
    .agu_load, .agu_store, .agu_lsu_op,
    .agu_address, .agu_byteenable, .agu_exception, .agu_ecause,
    .d_valid, .d_pc, .d_npc, .d_imm, .d_waddr, .d_wren, .d_rdata1, .d_rdata2,
    .d_alu_op, .d_lsu_op, .d_jump, .d_address, .d_exception, .d_ecause, .d_etval,
    .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb
  );

  rv_decoder u_rv_decoder (.dec (u_dec_if.decoder));

  rv_regfile u_rv_regfile (
    .clk, .rst,
    .rf (u_rf_if.regfile),
    .wb_wren, .wb_waddr, .wb_wdata,
    .ex_wren, .ex_waddr, .ex_wdata
  );

  rv_bcu u_rv_bcu (
    .rdata1 (bcu_rdata1),
    .rdata2 (bcu_rdata2),
    .bcu_op (bcu_op),
    .taken  (bcu_taken)
  );

  rv_agu u_rv_agu (
    .rdata1     (agu_rdata1),
    .imm        (agu_imm),
    .pc         (agu_pc),
    .jal        (agu_jal),
    .jalr       (agu_jalr),
    .branch     (agu_branch),
    .load       (agu_load),
    .store      (agu_store),
    .lsu_op     (agu_lsu_op),
    .address    (agu_address),
    .byteenable (agu_byteenable),
    .exception  (agu_exception),
    .ecause     (agu_ecause)
  );

endmodule

`default_nettype wire

// File: design/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_decoder import rv_pkg::*; (
  rv_dec_if.decoder dec
);

  logic [`RV_XLEN-1:0] instr;
  rv_opcode_e          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign instr  = dec.instr;
  assign opcode = rv_opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec.imm    = '0;
    dec.wren   = 1'b0;
    dec.rden1  = 1'b0;
    dec.rden2  = 1'b0;
    dec.lui    = 1'b0;
    dec.auipc  = 1'b0;
    dec.jal    = 1'b0;
    dec.jalr   = 1'b0;
    dec.branch = 1'b0;
    dec.load   = 1'b0;
    dec.store  = 1'b0;
    dec.fence  = 1'b0;
    dec.alu_op = alu_add;
    dec.bcu_op = bcu_none;
    dec.lsu_op = lsu_none;
    dec.ecall  = 1'b0;
    dec.ebreak = 1'b0;
    dec.valid  = 1'b0;

    case (opcode)
      opc_lui: begin
        {dec.imm, dec.wren, dec.lui, dec.valid} = {imm_u, 3'b111};
      end
      opc_auipc: begin
        {dec.imm, dec.wren, dec.auipc, dec.valid} = {imm_u, 3'b111};
      end
      opc_jal: begin
        {dec.imm, dec.wren, dec.jal, dec.valid} = {imm_j, 3'b111};
      end
      opc_jalr: begin
        {dec.imm, dec.wren, dec.rden1, dec.jalr} = {imm_i, 3'b111};
        dec.valid = (funct3 == 3'b000);
      end
      opc_branch: begin
        {dec.imm, dec.rden1, dec.rden2, dec.branch, dec.valid} = {imm_b, 4'b1111};
        case (funct3)
          3'b000:  dec.bcu_op = bcu_beq;
          3'b001:  dec.bcu_op = bcu_bne;
          3'b100:  dec.bcu_op = bcu_blt;
          3'b101:  dec.bcu_op = bcu_bge;
          3'b110:  dec.bcu_op = bcu_bltu;
          3'b111:  dec.bcu_op = bcu_bgeu;
          default: {dec.branch, dec.valid} = 2'b00;
        endcase
      end
      opc_load: begin
        {dec.imm, dec.wren, dec.rden1, dec.load, dec.valid} = {imm_i, 4'b1111};
        case (funct3)
          3'b000:  dec.lsu_op = lsu_lb;
          3'b001:  dec.lsu_op = lsu_lh;
          3'b010:  dec.lsu_op = lsu_lw;
          3'b100:  dec.lsu_op = lsu_lbu;
          3'b101:  dec.lsu_op = lsu_lhu;
          default: {dec.wren, dec.load, dec.valid} = 3'b000;
        endcase
      end
      opc_store: begin
        {dec.imm, dec.rden1, dec.rden2, dec.store, dec.valid} = {imm_s, 4'b1111};
        case (funct3)
          3'b000:  dec.lsu_op = lsu_sb;
          3'b001:  dec.lsu_op = lsu_sh;
          3'b010:  dec.lsu_op = lsu_sw;
          default: {dec.store, dec.valid} = 2'b00;
        endcase
      end
      opc_op_imm: begin
        {dec.imm, dec.wren, dec.rden1, dec.valid} = {imm_i, 3'b111};
        case (funct3)
          3'b000: dec.alu_op = alu_add;
          3'b010: dec.alu_op = alu_slt;
          3'b011: dec.alu_op = alu_sltu;
          3'b100: dec.alu_op = alu_xor;
          3'b110: dec.alu_op = alu_or;
          3'b111: dec.alu_op = alu_and;
          3'b001: begin
            dec.alu_op = alu_sll;
            dec.valid  = (funct7 == 7'b0000000);
          end
          default: begin // srli and srai share funct3
            dec.alu_op = funct7[5] ? alu_sra : alu_srl;
            dec.valid  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      opc_op: begin
        {dec.wren, dec.rden1, dec.rden2, dec.valid} = 4'b1111;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = alu_add;
          10'b0100000_000: dec.alu_op = alu_sub;
          10'b0000000_001: dec.alu_op = alu_sll;
          10'b0000000_010: dec.alu_op = alu_slt;
          10'b0000000_011: dec.alu_op = alu_sltu;
          10'b0000000_100: dec.alu_op = alu_xor;
          10'b0000000_101: dec.alu_op = alu_srl;
          10'b0100000_101: dec.alu_op = alu_sra;
          10'b0000000_110: dec.alu_op = alu_or;
          10'b0000000_111: dec.alu_op = alu_and;
          default:         dec.valid  = 1'b0;
        endcase
      end
      opc_misc_mem: begin
        dec.fence = (funct3 == 3'b000);
        dec.valid = (funct3 == 3'b000);
      end
      opc_system: begin
        dec.ecall  = (instr == 32'h0000_0073);
        dec.ebreak = (instr == 32'h0010_0073);
        dec.valid  = dec.ecall | dec.ebreak; // No CSR or mret support
      end
      default: dec.valid = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and address width
`define RV_XLEN 32

`define RV_RADDR_W 5 // Register address width
`define RV_NREGS 32

`endif

// File: design/rv_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

  typedef enum logic [6:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } rv_opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } rv_alu_op_e;

  typedef enum logic [2:0] {
    bcu_none, bcu_beq, bcu_bne, bcu_blt, bcu_bge, bcu_bltu, bcu_bgeu
  } rv_bcu_op_e;

  typedef enum logic [3:0] {
    lsu_none, lsu_lb, lsu_lbu, lsu_lh, lsu_lhu, lsu_lw, lsu_sb, lsu_sh, lsu_sw
  } rv_lsu_op_e;

  // Machine mode cause codes
  typedef enum logic [3:0] {
    exc_instr_misaligned = 4'd0,
    exc_illegal_instr    = 4'd2,
    exc_breakpoint       = 4'd3,
    exc_load_misaligned  = 4'd4,
    exc_store_misaligned = 4'd6,
    exc_ecall            = 4'd11
  } rv_ecause_e;

  typedef struct packed {
    logic                   valid;
    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_XLEN-1:0]    npc;
    logic [`RV_XLEN-1:0]    imm;
    logic [`RV_RADDR_W-1:0] waddr;
    logic                   wren;
    logic [`RV_XLEN-1:0]    rdata1;
    logic [`RV_XLEN-1:0]    rdata2;
    rv_alu_op_e             alu_op;
    rv_bcu_op_e             bcu_op;
    rv_lsu_op_e             lsu_op;
    logic                   lui;
    logic                   auipc;
    logic                   jal;
    logic                   jalr;
    logic                   branch;
    logic                   load;
    logic                   store;
    logic                   fence;
    logic                   jump;
    logic [`RV_XLEN-1:0]    address;
    logic [3:0]             byteenable;
    logic                   exception;
    rv_ecause_e             ecause;
    logic [`RV_XLEN-1:0]    etval;
  } rv_decode_reg_t;

  localparam rv_decode_reg_t rv_decode_reset = '0;

endpackage

`default_nettype wire

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   rst,
  rv_rf_if.regfile               rf,
  input  logic                   wb_wren,
  input  logic [`RV_RADDR_W-1:0] wb_waddr,
  input  logic [`RV_XLEN-1:0]    wb_wdata,
  input  logic                   ex_wren,
  input  logic [`RV_RADDR_W-1:0] ex_waddr,
  input  logic [`RV_XLEN-1:0]    ex_wdata
);

  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1]; // x0 is not stored

  // Execute result wins over writeback, then the array
  function automatic logic [`RV_XLEN-1:0] read_port(
    input logic                   rden,
    input logic [`RV_RADDR_W-1:0] raddr
  );
    logic [`RV_XLEN-1:0] data;
    if (!rden || raddr == '0) data = '0;
    else if (ex_wren && ex_waddr == raddr) data = ex_wdata;
    else if (wb_wren && wb_waddr == raddr) data = wb_wdata;
    else data = regs[raddr];
    return data;
  endfunction

  always_comb begin
    rf.rdata1 = read_port(rf.rden1, rf.raddr1);
    rf.rdata2 = read_port(rf.rden2, rf.raddr2);
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 1; i < `RV_NREGS; i++) regs[i] <= '0;
    end else if (wb_wren && wb_waddr != '0) begin
      regs[wb_waddr] <= wb_wdata;
    end
  end

endmodule

`default_nettype wire

// File: rv_decode.f
+incdir+design
design/rv_pkg.sv
design/rv_decode_if.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_bcu.sv
design/rv_agu.sv
design/rv_decode_stage.sv
design/rv_decode_top.sv
testbench/tb_rv_decode.sv

// File: testbench/tb_rv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode import rv_pkg::*; ();

  localparam logic [31:0] nop = 32'h0000_0013; // addi x0, x0, 0
  localparam int max_cycles = 400; // Tests need well under 100 cycles

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] pc;
  logic [31:0] instr;
  logic        stall;
  logic        clear;
  logic        wb_wren;
  logic [4:0]  wb_waddr;
  logic [31:0] wb_wdata;
  logic        ex_wren;
  logic [4:0]  ex_waddr;
  logic [31:0] ex_wdata;
  logic        d_valid;
  logic [31:0] d_pc;
  logic [31:0] d_npc;
  logic [31:0] d_imm;
  logic [4:0]  d_waddr;
  logic        d_wren;
  logic [31:0] d_rdata1;
  logic [31:0] d_rdata2;
  rv_alu_op_e  d_alu_op;
  rv_lsu_op_e  d_lsu_op;
  logic        d_jump;
  logic [31:0] d_address;
  logic        d_exception;
  rv_ecause_e  d_ecause;
  logic [31:0] d_etval;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;

  integer seed;
  int     cycle_count = 0;

  rv_decode_top u_rv_decode_top (
    .clk, .rst, .pc, .instr, .stall, .clear,
    .wb_wren, .wb_waddr, .wb_wdata, .ex_wren, .ex_waddr, .ex_wdata,
    .d_valid, .d_pc, .d_npc, .d_imm, .d_waddr, .d_wren, .d_rdata1, .d_rdata2,
    .d_alu_op, .d_lsu_op, .d_jump, .d_address, .d_exception, .d_ecause, .d_etval,
    .mem_valid, .mem_addr, .mem_wdata, .mem_wstrb
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: tests did not finish within %0d cycles", max_cycles);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // Instruction formats
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
      input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
      input logic [31:0] b);
    logic t;
    case (f3)
      3'b000:  t = (a == b);
      3'b001:  t = (a != b);
      3'b100:  t = ($signed(a) < $signed(b));
      3'b101:  t = ($signed(a) >= $signed(b));
      3'b110:  t = (a < b);
      3'b111:  t = (a >= b);
      default: t = 1'b0;
    endcase
    return t;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] expected,
      input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      $display("Result: FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Drive at edge plus 1 ns, leave 1 ns for the combinational outputs
  task automatic present(input logic [31:0] pc_v, input logic [31:0] instr_v);
    pc = pc_v;
    instr = instr_v;
    #1;
  endtask

  task automatic decode(input logic [31:0] pc_v, input logic [31:0] instr_v);
    present(pc_v, instr_v);
    next_cycle();
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_wren = 1'b1;
    wb_waddr = addr;
    wb_wdata = data;
    next_cycle();
    wb_wren = 1'b0;
  endtask

  task automatic reset_check();
    check(d_valid, 0, "d_valid after reset");
    check(d_wren, 0, "d_wren after reset");
    check(d_jump, 0, "d_jump after reset");
    check(d_exception, 0, "d_exception after reset");
    check(mem_valid, 0, "mem_valid after reset");
  endtask

  task automatic alu_operands();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = $random(seed);
    write_reg(5'd5, a);
    write_reg(5'd6, b);
    decode(32'h100, r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd7, opc_op));
    check(d_valid, 1, "add valid");
    check(d_alu_op, alu_add, "add alu_op");
    check(d_waddr, 7, "add waddr");
    check(d_npc, 32'h104, "add npc");
    check(d_rdata1, a, "add rdata1");
    check(d_rdata2, b, "add rdata2");
    decode(32'h104, r_type(7'h20, 5'd6, 5'd5, 3'b000, 5'd8, opc_op));
    check(d_alu_op, alu_sub, "sub alu_op");
    check(d_waddr, 8, "sub waddr");
    check(d_npc, 32'h108, "sub npc");
    ex_wren = 1'b1; // Writes to x0 in flight
    ex_waddr = 5'd0;
    ex_wdata = $random(seed);
    wb_wren = 1'b1;
    wb_waddr = 5'd0;
    wb_wdata = $random(seed);
    decode(32'h108, i_type(12'hfdb, 5'd0, 3'b000, 5'd9, opc_op_imm));
    ex_wren = 1'b0;
    wb_wren = 1'b0;
    check(d_imm, 32'hffff_ffdb, "addi imm");
    check(d_alu_op, alu_add, "addi alu_op");
    check(d_rdata1, 0, "x0 reads zero");
    decode(32'h10c, u_type(20'habcde, 5'd10, opc_lui));
    check(d_imm, 32'habcd_e000, "lui imm");
    check(d_waddr, 10, "lui waddr");
    check(d_wren, 1, "lui wren");
    decode(32'h110, u_type(20'h12345, 5'd11, opc_auipc));
    check(d_imm, 32'h1234_5000, "auipc imm");
    check(d_pc, 32'h110, "auipc pc");
    check(d_npc, 32'h114, "auipc npc");
  endtask

  task automatic forwarding_priority();
    logic [31:0] e;
    logic [31:0] w;
    logic [31:0] reader;
    e = $random(seed);
    w = $random(seed);
    reader = r_type(7'h00, 5'd13, 5'd13, 3'b000, 5'd14, opc_op);
    ex_wren = 1'b1;
    ex_waddr = 5'd13;
    ex_wdata = e;
    wb_wren = 1'b1;
    wb_waddr = 5'd13;
    wb_wdata = w;
    decode(32'h180, reader);
    check(d_rdata1, e, "execute forward rdata1");
    check(d_rdata2, e, "execute forward rdata2");
    ex_wren = 1'b0;
    decode(32'h184, reader);
    check(d_rdata1, w, "writeback forward rdata1");
    wb_wren = 1'b0;
    decode(32'h188, reader);
    check(d_rdata1, w, "register array rdata1");
  endtask

  task automatic branches_and_jumps();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] pc_v;
    int p;
    int k;
    pc_v = 32'h200;
    for (p = 0; p < 3; p++) begin
      if (p == 0) begin
        a = $random(seed);
        b = $random(seed);
      end else if (p == 1) begin
        b = a; // Equal operands
      end else begin
        a = a | 32'h8000_0000; // Signs differ
        b = b & 32'h7fff_ffff;
      end
      write_reg(5'd1, a);
      write_reg(5'd2, b);
      for (k = 0; k < 8; k++) begin
        if (k != 2 && k != 3) begin
          decode(pc_v, b_type(13'h0010, 5'd2, 5'd1, 3'(k)));
          check(d_jump, branch_taken(3'(k), a, b), $sformatf("branch f3=%0d jump", k));
          check(d_address, pc_v + 32'd16, "branch target");
          check(d_exception, 0, "branch exception");
          pc_v = pc_v + 32'd4;
        end
      end
    end
    decode(32'h300, j_type(21'h000800, 5'd1));
    check(d_jump, 1, "jal jump");
    check(d_address, 32'h0000_0b00, "jal target");
    check(d_wren, 1, "jal wren");
    write_reg(5'd3, 32'h0000_1001);
    decode(32'h304, i_type(12'h008, 5'd3, 3'b000, 5'd1, opc_jalr));
    check(d_jump, 1, "jalr jump");
    check(d_address, 32'h0000_1008, "jalr target bit 0 cleared");
  endtask

  task automatic mem_access(input logic [31:0] instr_v, input logic [31:0] addr,
      input logic [3:0] strb, input logic [31:0] wdata);
    present(32'h280, instr_v);
    check(mem_valid, 1, "mem_valid");
    check(mem_addr, addr, "mem_addr");
    check(mem_wstrb, strb, "mem_wstrb");
    if (strb != 4'b0000) check(mem_wdata, wdata, "mem_wdata");
    next_cycle();
    check(d_exception, 0, "aligned access exception");
  endtask

  task automatic loads_and_stores();
    logic [31:0] d;
    d = $random(seed);
    write_reg(5'd4, 32'h0000_2000);
    write_reg(5'd5, d);
    mem_access(i_type(12'd1, 5'd4, 3'b000, 5'd6, opc_load), 32'h2001, 4'b0000, 0);
    mem_access(i_type(12'd2, 5'd4, 3'b001, 5'd6, opc_load), 32'h2002, 4'b0000, 0);
    mem_access(i_type(12'd4, 5'd4, 3'b010, 5'd6, opc_load), 32'h2004, 4'b0000, 0);
    mem_access(s_type(12'd3, 5'd5, 5'd4, 3'b000), 32'h2003, 4'b1000, {4{d[7:0]}});
    mem_access(s_type(12'd2, 5'd5, 5'd4, 3'b001), 32'h2002, 4'b1100, {2{d[15:0]}});
    mem_access(s_type(12'd0, 5'd5, 5'd4, 3'b010), 32'h2000, 4'b1111, d);
  endtask

  task automatic expect_exception(input logic [31:0] pc_v, input logic [31:0] instr_v,
      input logic [3:0] cause, input logic [31:0] tval);
    present(pc_v, instr_v);
    check(mem_valid, 0, "mem_valid on exception");
    next_cycle();
    check(d_exception, 1, "exception raised");
    check(d_ecause, cause, "exception cause");
    check(d_etval, tval, "exception tval");
    check(d_wren, 0, "wren on exception");
  endtask

  task automatic exception_causes();
    logic [31:0] illegal;
    illegal = r_type(7'h01, 5'd2, 5'd1, 3'b000, 5'd7, opc_op); // mul needs the M extension
    expect_exception(32'h380, illegal, 4'd2, illegal);
    expect_exception(32'h384, 32'h0010_0073, 4'd3, 32'h0010_0073);
    expect_exception(32'h388, 32'h0000_0073, 4'd11, 32'h0000_0073);
    expect_exception(32'h38c, i_type(12'd2, 5'd4, 3'b010, 5'd6, opc_load), 4'd4,
                     32'h2002);
    expect_exception(32'h390, s_type(12'd1, 5'd5, 5'd4, 3'b010), 4'd6, 32'h2001);
    expect_exception(32'h400, j_type(21'h000006, 5'd1), 4'd0, 32'h406);
    check(d_jump, 0, "misaligned jal jump");
  endtask

  task automatic cleared(input logic [31:0] pc_v, input logic [31:0] instr_v);
    present(pc_v, instr_v);
    check(mem_valid, 0, "mem_valid under clear");
    next_cycle();
    check(d_valid, 0, "d_valid after clear");
    check(d_wren, 0, "d_wren after clear");
    check(d_jump, 0, "d_jump after clear");
    check(d_exception, 0, "d_exception after clear");
    check(d_pc, pc_v, "clear overrides stall");
  endtask

  task automatic stall_and_clear();
    decode(32'h500, i_type(12'd4, 5'd4, 3'b010, 5'd6, opc_load));
    stall = 1'b1;
    present(32'h600, u_type(20'h55555, 5'd10, opc_lui));
    check(mem_valid, 1, "held load mem_valid");
    check(mem_addr, 32'h2004, "held load mem_addr");
    next_cycle();
    check(d_valid, 1, "stalled valid");
    check(d_pc, 32'h500, "stalled pc");
    check(d_imm, 32'd4, "stalled imm");
    check(d_waddr, 6, "stalled waddr");
    check(d_lsu_op, lsu_lw, "stalled lsu_op");
    clear = 1'b1;
    cleared(32'h604, i_type(12'd4, 5'd4, 3'b010, 5'd6, opc_load));
    cleared(32'h608, j_type(21'h000010, 5'd1));
    cleared(32'h60c, 32'h0000_0073);
    clear = 1'b0;
    stall = 1'b0;
  endtask

  initial begin
    seed = 32'h26c5;
    rst = 1'b0;
    pc = '0;
    instr = nop;
    stall = 1'b0;
    clear = 1'b0;
    wb_wren = 1'b0;
    wb_waddr = '0;
    wb_wdata = '0;
    ex_wren = 1'b0;
    ex_waddr = '0;
    ex_wdata = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b1;
    reset_check();
    alu_operands();
    forwarding_priority();
    branches_and_jumps();
    loads_and_stores();
    exception_causes();
    stall_and_clear();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
